// File: sources.f
cache_pkg.sv
bus_pkg.sv
req_fifo.sv
port_arbiter.sv
miss_unit.sv
l2_ctrl.sv
l2_ctrl_chk.sv
tb_l2_ctrl.sv

// File: Makefile
SIM      := verilator
TOP      := tb_l2_ctrl
FILELIST := sources.f
FLAGS    := --binary --timing --assert -Wno-fatal
OBJ_DIR  := obj_dir
PASS_MSG := RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_l2_ctrl.sv
`timescale 1ns/10ps

module tb_l2_ctrl;

  localparam int rst_cycles = 10;
  localparam int stim_cycles = 3000;
  localparam int drain_cycles = 990; // 64 queued items at most, wide margin
  localparam int cycle_limit = rst_cycles + stim_cycles + drain_cycles;
  localparam int aw = cache_pkg::addr_w;
  localparam int rw = cache_pkg::req_w;
  localparam int dw = cache_pkg::data_w;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic write_en = 1'b0;
  logic [aw-1:0] write_addr = '0;
  logic [dw-1:0] write_data = '0;
  logic code_en = 1'b0;
  logic [aw-1:0] code_addr = '0;
  logic [rw-1:0] code_req = '0;
  logic read_en = 1'b0;
  logic [aw-1:0] read_addr = '0;
  logic [rw-1:0] read_req = '0;
  logic read_excl = 1'b0;
  logic miss_en = 1'b0;
  logic [aw-1:0] miss_addr = '0;
  logic [rw-1:0] miss_req = '0;
  logic miss_excl = 1'b0;
  logic rbus_can = 1'b0;
  logic reply_valid = 1'b0;
  logic [bus_pkg::bus_req_w-1:0] reply_dst = '0;
  logic [dw-1:0] reply_data = '0;
  cache_pkg::port_op_e port_op;
  logic [aw-1:0] port_addr;
  logic [rw-1:0] port_req;
  logic [dw-1:0] port_data;
  logic port_excl;
  logic rbus_want;
  logic rbus_used;
  logic [aw-1:0] rbus_addr;
  logic [bus_pkg::bus_req_w-1:0] rbus_src_req;
  bus_pkg::bus_op_e rbus_op;
  logic rbus_excl;
  logic stall;

  // reference model
  logic [aw+dw-1:0] store_q [$];
  logic [aw+rw-1:0] code_q [$];
  logic [aw+rw:0] read_q [$];
  logic [aw+rw:0] miss_q [$];
  logic [aw-1:0] tag_model [2**rw];
  bit tag_valid [2**rw];
  bit fill_d1;
  bit fill_d2;
  logic [aw+rw+dw-1:0] fill_exp_d1; // {addr, req, data}
  logic [aw+rw+dw-1:0] fill_exp_d2;
  int seed = 32'h32b6_a042;
  int cycles = 0;
  int err_count = 0;
  bit drained;

  l2_ctrl u_dut (.*);

  always #4 clk = ~clk;

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit)
    begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [127:0] random_wide();
    random_wide = {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  task automatic report_mismatch(input string what);
    err_count++;
    $display("mismatch at time %0t: %s", $time, what);
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  // called at a rising edge, values land after the edge
  task automatic drive_inputs(input bit active);
    logic [31:0] r;
    logic [127:0] w;
    logic [127:0] w2;
    r = $random(seed);
    w = random_wide();
    w2 = random_wide();
    write_en <= active && r[0] && store_q.size() < cache_pkg::store_depth;
    read_en <= active && r[3:2] == 2'b00 && read_q.size() < cache_pkg::read_depth;
    code_en <= active && r[6:4] == 3'b000 && code_q.size() < cache_pkg::code_depth;
    miss_en <= active && r[8:7] == 2'b00 && miss_q.size() < bus_pkg::miss_depth;
    rbus_can <= active ? r[10] : 1'b1; // grant always given while draining
    write_addr <= w[36:0];
    code_addr <= w[73:37];
    read_addr <= w[110:74];
    miss_addr <= w2[36:0];
    code_req <= w2[41:37];
    read_req <= w2[46:42];
    read_excl <= w2[47];
    miss_req <= w2[52:48];
    miss_excl <= w2[53];
    write_data <= random_wide();
    reply_data <= random_wide();
    if (active && r[13:11] == 3'b000 && r[14])
    begin
      reply_valid <= 1'b1;
      reply_dst <= {r[25:21] | 5'd1, r[20:16]}; // some other node
    end
    else if (active && r[13:11] == 3'b000 && tag_valid[r[20:16]])
    begin
      reply_valid <= 1'b1;
      reply_dst <= {bus_pkg::node_id, r[20:16]};
    end
    else
    begin
      reply_valid <= 1'b0;
      reply_dst <= '0;
    end
  endtask

  // called at a falling edge, outputs are settled
  task automatic check_cycle();
    logic [aw-1:0] a;
    logic [rw-1:0] q;
    logic [dw-1:0] d;
    logic x;
    bus_pkg::bus_op_e exp_op;
    if (fill_d2)
      assert (port_op == cache_pkg::op_fill && !port_excl &&
              {port_addr, port_req, port_data} == fill_exp_d2)
        else report_mismatch($sformatf("fill expected, op %0d addr %h req %0d",
                                       port_op, port_addr, port_req));
    else
    begin
      assert (port_op != cache_pkg::op_fill) else report_mismatch("fill with no reply");
      case (port_op)
        cache_pkg::op_store:
        begin
          assert (store_q.size() != 0) else report_mismatch("store with none queued");
          {a, d} = store_q.pop_front();
          assert (port_addr == a && port_data == d && port_req == '0 && !port_excl)
            else report_mismatch($sformatf("store addr %h, expected %h", port_addr, a));
        end
        cache_pkg::op_code_read:
        begin
          assert (code_q.size() != 0) else report_mismatch("code read with none queued");
          {a, q} = code_q.pop_front();
          assert (port_addr == a && port_req == q && port_data == '0 && !port_excl)
            else report_mismatch($sformatf("code read addr %h, expected %h", port_addr, a));
        end
        cache_pkg::op_data_read:
        begin
          assert (read_q.size() != 0) else report_mismatch("data read with none queued");
          {a, q, x} = read_q.pop_front();
          assert (port_addr == a && port_req == q && port_excl == x && port_data == '0)
            else report_mismatch($sformatf("data read addr %h, expected %h", port_addr, a));
        end
        default: ;
      endcase
    end
    assert (rbus_want == (miss_q.size() != 0)) else report_mismatch("rbus_want wrong");
    assert (rbus_used == (miss_q.size() != 0 && rbus_can))
      else report_mismatch("rbus_used wrong");
    if (rbus_used)
    begin
      {a, q, x} = miss_q.pop_front();
      exp_op = (q[4] && !q[3]) ? bus_pkg::bus_code_read : bus_pkg::bus_mem_read;
      assert (rbus_addr == a && rbus_src_req == {bus_pkg::node_id, q} &&
              rbus_op == exp_op && rbus_excl == x)
        else report_mismatch($sformatf("ring addr %h src %h, expected %h req %0d",
                                       rbus_addr, rbus_src_req, a, q));
    end
    assert (stall == (store_q.size() >= cache_pkg::stall_cnt))
      else report_mismatch($sformatf("stall %b with %0d stores", stall, store_q.size()));
    // record what the DUT takes at the next edge
    if (write_en)
      store_q.push_back({write_addr, write_data});
    if (code_en)
      code_q.push_back({code_addr, code_req});
    if (read_en)
      read_q.push_back({read_addr, read_req, read_excl});
    if (miss_en)
      miss_q.push_back({miss_addr, miss_req, miss_excl});
    fill_d2 = fill_d1;
    fill_exp_d2 = fill_exp_d1;
    fill_d1 = reply_valid && reply_dst[9:5] == bus_pkg::node_id;
    fill_exp_d1 = {tag_model[reply_dst[4:0]], reply_dst[4:0], reply_data}; // tag before write
    if (miss_en)
    begin
      tag_model[miss_req] = miss_addr;
      tag_valid[miss_req] = 1'b1;
    end
  endtask

  initial
  begin
    repeat (rst_cycles) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert (port_op == cache_pkg::op_none && !rbus_want && !rbus_used && !stall)
      else report_mismatch("outputs not idle after reset");
    repeat (stim_cycles)
    begin
      @(posedge clk);
      drive_inputs(1'b1);
      @(negedge clk);
      check_cycle();
    end
    drained = 1'b0;
    while (!drained)
    begin
      @(posedge clk);
      drive_inputs(1'b0);
      @(negedge clk);
      check_cycle();
      drained = store_q.size() == 0 && code_q.size() == 0 && read_q.size() == 0 &&
                miss_q.size() == 0 && !fill_d1 && !fill_d2 && !rbus_want;
    end
    if (err_count == 0)
    begin
      $display("RESULT: PASS");
      $finish;
    end
    else
    begin
      $display("RESULT: FAIL");
      $fatal(1, "checks failed");
    end
  end

endmodule

// File: l2_ctrl_chk.sv
`timescale 1ns/10ps

module l2_ctrl_chk (
  input logic                              clk,
  input logic                              rst,
  input logic                              rbus_can,
  input logic                              rbus_used,
  input cache_pkg::port_op_e               port_op,
  input logic                              write_en,
  input logic [cache_pkg::store_cnt_w-1:0] store_count,
  input logic                              code_en,
  input logic                              code_pop,
  input logic                              read_en,
  input logic                              read_pop,
  input logic                              miss_en
);

  logic [5:0] code_cnt;
  logic [5:0] read_cnt;
  logic [5:0] miss_cnt;

  // shadow occupancy where the queue count is left open
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      code_cnt <= '0;
      read_cnt <= '0;
      miss_cnt <= '0;
    end
    else
    begin
      code_cnt <= code_cnt + 6'(code_en) - 6'(code_pop);
      read_cnt <= read_cnt + 6'(read_en) - 6'(read_pop);
      miss_cnt <= miss_cnt + 6'(miss_en) - 6'(rbus_used); // ring grant pops the miss queue
    end
  end

  used_has_grant: assert property (@(posedge clk) disable iff (rst) rbus_used |-> rbus_can)
    else $error("ring request taken without grant");

  port_op_legal: assert property (@(posedge clk) disable iff (rst)
    port_op inside {cache_pkg::op_none, cache_pkg::op_store, cache_pkg::op_code_read,
                    cache_pkg::op_data_read, cache_pkg::op_fill})
    else $error("illegal port opcode");

  no_full_push: assert property (@(posedge clk) disable iff (rst)
    !(write_en && store_count == cache_pkg::store_depth) &&
    !(code_en && code_cnt == cache_pkg::code_depth) &&
    !(read_en && read_cnt == cache_pkg::read_depth) &&
    !(miss_en && miss_cnt == bus_pkg::miss_depth))
    else $error("push into a full queue");

endmodule

bind l2_ctrl l2_ctrl_chk u_chk (.*);

// File: l2_ctrl.sv
`timescale 1ns/10ps

module l2_ctrl (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              write_en,
  input  logic [cache_pkg::addr_w-1:0]      write_addr,
  input  logic [cache_pkg::data_w-1:0]      write_data,
  input  logic                              code_en,
  input  logic [cache_pkg::addr_w-1:0]      code_addr,
  input  logic [cache_pkg::req_w-1:0]       code_req,
  input  logic                              read_en,
  input  logic [cache_pkg::addr_w-1:0]      read_addr,
  input  logic [cache_pkg::req_w-1:0]       read_req,
  input  logic                              read_excl,
  input  logic                              miss_en,
  input  logic [cache_pkg::addr_w-1:0]      miss_addr,
  input  logic [cache_pkg::req_w-1:0]       miss_req,
  input  logic                              miss_excl,
  input  logic                              rbus_can,
  input  logic                              reply_valid,
  input  logic [bus_pkg::bus_req_w-1:0]     reply_dst,
  input  logic [cache_pkg::data_w-1:0]      reply_data,
  output cache_pkg::port_op_e               port_op,
  output logic [cache_pkg::addr_w-1:0]      port_addr,
  output logic [cache_pkg::req_w-1:0]       port_req,
  output logic [cache_pkg::data_w-1:0]      port_data,
  output logic                              port_excl,
  output logic                              rbus_want,
  output logic                              rbus_used,
  output logic [cache_pkg::addr_w-1:0]      rbus_addr,
  output logic [bus_pkg::bus_req_w-1:0]     rbus_src_req,
  output bus_pkg::bus_op_e                  rbus_op,
  output logic                              rbus_excl,
  output logic                              stall
);

  logic [cache_pkg::addr_w+cache_pkg::data_w-1:0] store_head;
  logic                                            store_nonempty;
  logic                                            store_pop;
  logic [cache_pkg::store_cnt_w-1:0]               store_count;
  logic [cache_pkg::addr_w+cache_pkg::req_w-1:0]   code_head;
  logic                                            code_nonempty;
  logic                                            code_pop;
  logic [cache_pkg::addr_w+cache_pkg::req_w:0]     read_head;
  logic                                            read_nonempty;
  logic                                            read_pop;
  logic                                            fill_valid;
  logic [cache_pkg::addr_w-1:0]                    fill_addr;
  logic [cache_pkg::req_w-1:0]                     fill_req;
  logic [cache_pkg::data_w-1:0]                    fill_data;

  req_fifo #(
    .depth(cache_pkg::store_depth),
    .width(cache_pkg::addr_w + cache_pkg::data_w)
  ) u_store_q (
    .clk(clk),
    .rst(rst),
    .push(write_en),
    .push_data({write_addr, write_data}),
    .pop(store_pop),
    .head(store_head),
    .nonempty(store_nonempty),
    .count(store_count)
  );

  req_fifo #(
    .depth(cache_pkg::code_depth),
    .width(cache_pkg::addr_w + cache_pkg::req_w)
  ) u_code_q (
    .clk(clk),
    .rst(rst),
    .push(code_en),
    .push_data({code_addr, code_req}),
    .pop(code_pop),
    .head(code_head),
    .nonempty(code_nonempty),
    .count()
  );

  req_fifo #(
    .depth(cache_pkg::read_depth),
    .width(cache_pkg::addr_w + cache_pkg::req_w + 1)
  ) u_read_q (
    .clk(clk),
    .rst(rst),
    .push(read_en),
    .push_data({read_addr, read_req, read_excl}),
    .pop(read_pop),
    .head(read_head),
    .nonempty(read_nonempty),
    .count()
  );

  miss_unit u_miss (
    .clk(clk),
    .rst(rst),
    .miss_en(miss_en),
    .miss_addr(miss_addr),
    .miss_req(miss_req),
    .miss_excl(miss_excl),
    .rbus_can(rbus_can),
    .reply_valid(reply_valid),
    .reply_dst(reply_dst),
    .reply_data(reply_data),
    .rbus_want(rbus_want),
    .rbus_used(rbus_used),
    .rbus_addr(rbus_addr),
    .rbus_src_req(rbus_src_req),
    .rbus_op(rbus_op),
    .rbus_excl(rbus_excl),
    .fill_valid(fill_valid),
    .fill_addr(fill_addr),
    .fill_req(fill_req),
    .fill_data(fill_data)
  );

  port_arbiter u_arb (
    .clk(clk),
    .rst(rst),
    .fill_valid(fill_valid),
    .fill_addr(fill_addr),
    .fill_req(fill_req),
    .fill_data(fill_data),
    .read_nonempty(read_nonempty),
    .read_head(read_head),
    .code_nonempty(code_nonempty),
    .code_head(code_head),
    .store_nonempty(store_nonempty),
    .store_head(store_head),
    .read_pop(read_pop),
    .code_pop(code_pop),
    .store_pop(store_pop),
    .port_op(port_op),
    .port_addr(port_addr),
    .port_req(port_req),
    .port_data(port_data),
    .port_excl(port_excl)
  );

  assign stall = store_count >= cache_pkg::stall_cnt; // store queue near full

endmodule

// File: miss_unit.sv
`timescale 1ns/10ps

module miss_unit (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              miss_en,
  input  logic [cache_pkg::addr_w-1:0]      miss_addr,
  input  logic [cache_pkg::req_w-1:0]       miss_req,
  input  logic                              miss_excl,
  input  logic                              rbus_can,
  input  logic                              reply_valid,
  input  logic [bus_pkg::bus_req_w-1:0]     reply_dst,
  input  logic [cache_pkg::data_w-1:0]      reply_data,
  output logic                              rbus_want,
  output logic                              rbus_used,
  output logic [cache_pkg::addr_w-1:0]      rbus_addr,
  output logic [bus_pkg::bus_req_w-1:0]     rbus_src_req,
  output bus_pkg::bus_op_e                  rbus_op,
  output logic                              rbus_excl,
  output logic                              fill_valid,
  output logic [cache_pkg::addr_w-1:0]      fill_addr,
  output logic [cache_pkg::req_w-1:0]       fill_req,
  output logic [cache_pkg::data_w-1:0]      fill_data
);

  logic [cache_pkg::addr_w+cache_pkg::req_w:0] miss_head; // {addr, req, excl}
  logic [cache_pkg::addr_w-1:0]                tag_ram [2**cache_pkg::req_w];
  logic [cache_pkg::req_w-1:0]                 reply_req;
  logic                                        reply_hit;

  req_fifo #(
    .depth(bus_pkg::miss_depth),
    .width(cache_pkg::addr_w + cache_pkg::req_w + 1)
  ) u_miss_q (
    .clk(clk),
    .rst(rst),
    .push(miss_en),
    .push_data({miss_addr, miss_req, miss_excl}),
    .pop(rbus_used),
    .head(miss_head),
    .nonempty(rbus_want),
    .count()
  );

  assign rbus_used = rbus_want && rbus_can;
  assign rbus_addr = miss_head[cache_pkg::addr_w+cache_pkg::req_w -: cache_pkg::addr_w];
  assign rbus_src_req = {bus_pkg::node_id, miss_head[cache_pkg::req_w:1]};
  assign rbus_excl = miss_head[0];

  // code fetch ids have bit 4 set and bit 3 clear
  assign rbus_op = (rbus_src_req[4] && !rbus_src_req[3]) ? bus_pkg::bus_code_read
                                                         : bus_pkg::bus_mem_read;

  // line address by request id, for matching replies
  always_ff @(posedge clk)
  begin
    if (miss_en)
      tag_ram[miss_req] <= miss_addr;
  end

  assign reply_req = reply_dst[cache_pkg::req_w-1:0];
  assign reply_hit = reply_valid &&
    reply_dst[bus_pkg::bus_req_w-1 -: bus_pkg::node_w] == bus_pkg::node_id;

  always_ff @(posedge clk)
  begin
    if (rst)
      fill_valid <= 1'b0;
    else
      fill_valid <= reply_hit; // one cycle per reply
  end

  always_ff @(posedge clk)
  begin
    fill_addr <= tag_ram[reply_req];
    fill_req <= reply_req;
    fill_data <= reply_data;
  end

endmodule

// File: port_arbiter.sv
`timescale 1ns/10ps

module port_arbiter (
  input  logic                                        clk,
  input  logic                                        rst,
  input  logic                                        fill_valid,
  input  logic [cache_pkg::addr_w-1:0]                fill_addr,
  input  logic [cache_pkg::req_w-1:0]                 fill_req,
  input  logic [cache_pkg::data_w-1:0]                fill_data,
  input  logic                                        read_nonempty,
  input  logic [cache_pkg::addr_w+cache_pkg::req_w:0] read_head,
  input  logic                                        code_nonempty,
  input  logic [cache_pkg::addr_w+cache_pkg::req_w-1:0] code_head,
  input  logic                                        store_nonempty,
  input  logic [cache_pkg::addr_w+cache_pkg::data_w-1:0] store_head,
  output logic                                        read_pop,
  output logic                                        code_pop,
  output logic                                        store_pop,
  output cache_pkg::port_op_e                         port_op,
  output logic [cache_pkg::addr_w-1:0]                port_addr,
  output logic [cache_pkg::req_w-1:0]                 port_req,
  output logic [cache_pkg::data_w-1:0]                port_data,
  output logic                                        port_excl
);

  cache_pkg::port_op_e               op_nxt;
  logic [cache_pkg::addr_w-1:0]      addr_nxt;
  logic [cache_pkg::req_w-1:0]       req_nxt;
  logic [cache_pkg::data_w-1:0]      data_nxt;
  logic                              excl_nxt;

  // fill > data read > code read > store
  always_comb
  begin
    op_nxt = cache_pkg::op_none;
    addr_nxt = '0;
    req_nxt = '0;
    data_nxt = '0;
    excl_nxt = 1'b0;
    if (fill_valid)
    begin
      op_nxt = cache_pkg::op_fill;
      addr_nxt = fill_addr;
      req_nxt = fill_req;
      data_nxt = fill_data;
    end
    else if (read_nonempty)
    begin
      op_nxt = cache_pkg::op_data_read;
      {addr_nxt, req_nxt, excl_nxt} = read_head;
    end
    else if (code_nonempty)
    begin
      op_nxt = cache_pkg::op_code_read;
      {addr_nxt, req_nxt} = code_head;
    end
    else if (store_nonempty)
    begin
      op_nxt = cache_pkg::op_store;
      {addr_nxt, data_nxt} = store_head;
    end
  end

  // fill has no queue behind it, so no pop
  assign read_pop = op_nxt == cache_pkg::op_data_read;
  assign code_pop = op_nxt == cache_pkg::op_code_read;
  assign store_pop = op_nxt == cache_pkg::op_store;

  always_ff @(posedge clk)
  begin
    if (rst)
      port_op <= cache_pkg::op_none;
    else
      port_op <= op_nxt;
  end

  always_ff @(posedge clk)
  begin
    port_addr <= addr_nxt;
    port_req <= req_nxt;
    port_data <= data_nxt;
    port_excl <= excl_nxt;
  end

endmodule

// File: req_fifo.sv
`timescale 1ns/10ps

module req_fifo #(
  parameter int depth = 16,
  parameter int width = 8
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         push,
  input  logic [width-1:0]             push_data,
  input  logic                         pop,
  output logic [width-1:0]             head,
  output logic                         nonempty,
  output logic [$clog2(depth+1)-1:0]   count
);

  localparam int ptr_w = $clog2(depth);

  logic [width-1:0] ram [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;

  assign head = ram[rd_ptr]; // show-ahead
  assign nonempty = count != '0;

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      ram[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      // push and pop together leave the count alone
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

endmodule

// File: bus_pkg.sv
package bus_pkg;

  localparam int node_w = 5;
  localparam logic [node_w-1:0] node_id = 5'd0; // our stop on the ring

  // src/dst tag is node id on top, request id below
  localparam int bus_req_w = 10;

  localparam int miss_depth = 24; // not a power of two

  // ring request type
  typedef enum logic {
    bus_mem_read,
    bus_code_read
  } bus_op_e;

endpackage

// File: cache_pkg.sv
package cache_pkg;

  // line address and payload widths
  localparam int addr_w = 37;
  localparam int data_w = 128;
  localparam int req_w = 5;

  // queue depths on the cache side
  localparam int store_depth = 16;
  localparam int code_depth = 8;
  localparam int read_depth = 16;

  // width of the store occupancy count, one more state than entries
  localparam int store_cnt_w = $clog2(store_depth + 1);

  localparam logic [store_cnt_w-1:0] stall_cnt = 12; // stores outstanding before stall

  // what the cache port is doing this cycle
  typedef enum logic [2:0] {
    op_none,
    op_store,
    op_code_read,
    op_data_read,
    op_fill
  } port_op_e;

endpackage
